//--- cpuPkg.sv
package cpuPkg;

    // datapath and memory widths
    localparam int dataWidth = 8;
    localparam int addrWidth = 8;
    localparam int wordWidth = 16;
    localparam int memDepth = 1 << addrWidth;

    typedef logic [dataWidth-1:0] data_t;
    typedef logic [addrWidth-1:0] addr_t;
    typedef logic [wordWidth-1:0] word_t;

    // opcodes 8..15 are reserved and run as NOP
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LDA,
        ADD,
        SUB,
        AND,
        STA,
        JMP,
        HLT
    } opcode_e;

    // mode 3 is unused and addresses like DIR
    typedef enum logic [1:0] {
        IMM = 2'd0,
        DIR,
        IND
    } mode_e;

    typedef enum logic [3:0] {
        ALWAYS = 4'd0,
        ZERO,
        NEG,
        NONZERO
    } cond_e;

    // alu and store instructions
    typedef struct packed {
        opcode_e opcode;
        mode_e mode;
        logic [1:0] reserved;
        data_t operand;
    } aluForm_t;

    // jump instructions, cond sits where mode would be
    typedef struct packed {
        opcode_e opcode;
        cond_e cond;
        addr_t target;
    } jumpForm_t;

    typedef union packed {
        aluForm_t aluForm;
        jumpForm_t jumpForm;
    } instr_u;

    // phase step counter width
    typedef logic [2:0] tcode_t;

    // one-hot-ish control word for the datapath
    typedef struct packed {
        logic fetch;
        logic marFromOperand;
        logic marFromMem;
        logic execute;
        logic memWrite;
        logic jump;
    } ctrl_t;

    // operation phase is always execute then fetch
    localparam tcode_t opTiming = 3'd1;
    // addressing phase lengths minus one
    localparam tcode_t dirTiming = 3'd0;
    localparam tcode_t indTiming = 3'd1;

endpackage

//--- timingGenerator.sv
`timescale 1ns/1ns

module timingGenerator (
    input logic clk,
    input logic rst,
    input logic passAddressing,
    input cpuPkg::tcode_t addressTimingCode,
    input cpuPkg::tcode_t opTimingCode,
    output cpuPkg::tcode_t timeOut,
    output logic isAddressing
);
    import cpuPkg::*;

    // steps left in the current phase
    tcode_t negTime;
    // length code the current phase was loaded with
    tcode_t phaseCode;
    tcode_t nextCode;

    // code of the phase that follows when the counter runs out
    always_comb begin
        if (isAddressing || passAddressing) begin
            nextCode = opTimingCode;
        end else begin
            nextCode = addressTimingCode;
        end
    end

    // count up view of the down-counter
    // taken from registers only, so no loop back through the decoder
    assign timeOut = phaseCode - negTime;

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            negTime <= '0;
            phaseCode <= '0;
        end else if (negTime == '0) begin
            // reload for the next phase
            negTime <= nextCode;
            phaseCode <= nextCode;
        end else begin
            negTime <= negTime - tcode_t'(1);
        end
    end

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            isAddressing <= 1'b1;
        end else if (passAddressing) begin
            // no addressing needed, stay in or enter operations
            isAddressing <= 1'b0;
        end else if (negTime == '0) begin
            isAddressing <= !isAddressing;
        end
    end

endmodule

//--- microDecoder.sv
`timescale 1ns/1ns

module microDecoder (
    input cpuPkg::instr_u ir,
    input cpuPkg::word_t procReadData,
    input cpuPkg::tcode_t timeOut,
    input logic isAddressing,
    output cpuPkg::tcode_t addressTimingCode,
    output cpuPkg::tcode_t opTimingCode,
    output logic passAddressing,
    output cpuPkg::ctrl_t ctrl
);
    import cpuPkg::*;

    instr_u incoming;
    instr_u nextInstr;
    logic fetchStep;

    // true when the instruction has no addressing phase
    function automatic logic skipsAddressing(instr_u instr);
        case (instr.aluForm.opcode)
            LDA, ADD, SUB, AND, STA: return instr.aluForm.mode == IMM;
            // NOP, JMP, HLT and reserved opcodes
            default: return 1'b1;
        endcase
    endfunction

    // addressing phase length from the mode
    function automatic tcode_t addressCode(mode_e mode);
        if (mode == IND) begin
            return indTiming;
        end
        return dirTiming;
    endfunction

    assign incoming = instr_u'(procReadData);

    // last step of the operation phase
    assign fetchStep = !isAddressing && (timeOut == opTiming);

    // during fetch the word being loaded decides what follows
    assign nextInstr = fetchStep ? incoming : ir;

    assign passAddressing = skipsAddressing(nextInstr);
    assign addressTimingCode = addressCode(nextInstr.aluForm.mode);
    assign opTimingCode = opTiming;

    always_comb begin
        ctrl = '0;
        if (isAddressing) begin
            // nothing to do for pass instructions, only seen right after reset
            if (!skipsAddressing(ir)) begin
                if (timeOut == '0) begin
                    ctrl.marFromOperand = 1'b1;
                end else if (ir.aluForm.mode == IND) begin
                    // second indirect step, follow the pointer
                    ctrl.marFromMem = 1'b1;
                end
            end
        end else if (timeOut == '0) begin
            // execute step
            case (ir.aluForm.opcode)
                LDA, ADD, SUB, AND, HLT: ctrl.execute = 1'b1;
                // immediate store has no address to write
                STA: ctrl.memWrite = ir.aluForm.mode != IMM;
                JMP: ctrl.jump = 1'b1;
                default: ctrl = '0;
            endcase
        end else begin
            ctrl.fetch = 1'b1;
        end
    end

endmodule

//--- cpuDatapath.sv
`timescale 1ns/1ns

module cpuDatapath (
    input logic clk,
    input logic rst,
    input cpuPkg::ctrl_t ctrl,
    input cpuPkg::word_t procReadData,
    output cpuPkg::instr_u ir,
    output cpuPkg::addr_t procAddr,
    output logic procWrite,
    output cpuPkg::data_t procWriteData,
    output cpuPkg::data_t acc,
    output cpuPkg::addr_t pc,
    output logic halted
);
    import cpuPkg::*;

    addr_t mar;
    data_t memByte;
    data_t operand;
    data_t aluResult;
    logic zeroFlag;
    logic negFlag;
    logic condTrue;

    // operands are the low byte of a word
    assign memByte = procReadData[dataWidth-1:0];

    // immediate or the byte at MAR
    assign operand = (ir.aluForm.mode == IMM) ? ir.aluForm.operand : memByte;

    // flags straight off the accumulator
    assign zeroFlag = acc == '0;
    assign negFlag = acc[dataWidth-1];

    always_comb begin
        case (ir.aluForm.opcode)
            LDA: aluResult = operand;
            // wraps modulo 256
            ADD: aluResult = acc + operand;
            SUB: aluResult = acc - operand;
            AND: aluResult = acc & operand;
            default: aluResult = acc;
        endcase
    end

    // jump condition on the current acc
    always_comb begin
        case (ir.jumpForm.cond)
            ALWAYS: condTrue = 1'b1;
            ZERO: condTrue = zeroFlag;
            NEG: condTrue = negFlag;
            NONZERO: condTrue = !zeroFlag;
            default: condTrue = 1'b0;
        endcase
    end

    // PC addresses memory only while fetching
    assign procAddr = ctrl.fetch ? pc : mar;
    assign procWrite = ctrl.memWrite && !halted;
    assign procWriteData = acc;

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            pc <= '0;
            ir <= '0;
            acc <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (ctrl.fetch) begin
                ir <= instr_u'(procReadData);
                pc <= pc + addr_t'(1);
            end
            // PC already points past the JMP here
            if (ctrl.jump && condTrue) begin
                pc <= ir.jumpForm.target;
            end
            if (ctrl.execute) begin
                if (ir.aluForm.opcode == HLT) begin
                    halted <= 1'b1;
                end else begin
                    acc <= aluResult;
                end
            end
        end
    end

    // operand address register
    always_ff @(posedge clk) begin
        if (!halted) begin
            if (ctrl.marFromOperand) begin
                mar <= ir.aluForm.operand;
            end else if (ctrl.marFromMem) begin
                // pointer word gives the final address
                mar <= memByte;
            end
        end
    end

endmodule

//--- unifiedMemory.sv
`timescale 1ns/1ns

module unifiedMemory (
    input logic clk,
    input logic hostWrite,
    input cpuPkg::addr_t hostAddr,
    input cpuPkg::word_t hostWriteData,
    output cpuPkg::word_t hostReadData,
    input cpuPkg::addr_t procAddr,
    input logic procWrite,
    input cpuPkg::data_t procWriteData,
    output cpuPkg::word_t procReadData
);
    import cpuPkg::*;

    // program and data share one array
    word_t mem [0:memDepth-1];

    // both ports read asynchronously
    assign hostReadData = mem[hostAddr];
    assign procReadData = mem[procAddr];

    always_ff @(posedge clk) begin
        if (procWrite) begin
            // stores put the accumulator in the low byte
            mem[procAddr] <= {{(wordWidth - dataWidth){1'b0}}, procWriteData};
        end
        // host comes last, so it wins on the same address
        if (hostWrite) begin
            mem[hostAddr] <= hostWriteData;
        end
    end

endmodule

//--- tinyCpu.sv
`timescale 1ns/1ns

module tinyCpu (
    input logic clk,
    input logic rst,
    input logic hostWrite,
    input cpuPkg::addr_t hostAddr,
    input cpuPkg::word_t hostWriteData,
    output cpuPkg::word_t hostReadData,
    output cpuPkg::data_t acc,
    output cpuPkg::addr_t pc,
    output logic halted
);
    import cpuPkg::*;

    // sequencing
    tcode_t addressTimingCode;
    tcode_t opTimingCode;
    tcode_t timeOut;
    logic passAddressing;
    logic isAddressing;

    // decoder to datapath
    instr_u ir;
    ctrl_t ctrl;

    // processor memory port
    addr_t procAddr;
    logic procWrite;
    data_t procWriteData;
    word_t procReadData;

    timingGenerator i_timingGenerator (
        .clk(clk),
        .rst(rst),
        .passAddressing(passAddressing),
        .addressTimingCode(addressTimingCode),
        .opTimingCode(opTimingCode),
        .timeOut(timeOut),
        .isAddressing(isAddressing)
    );

    microDecoder i_microDecoder (
        .ir(ir),
        .procReadData(procReadData),
        .timeOut(timeOut),
        .isAddressing(isAddressing),
        .addressTimingCode(addressTimingCode),
        .opTimingCode(opTimingCode),
        .passAddressing(passAddressing),
        .ctrl(ctrl)
    );

    cpuDatapath i_cpuDatapath (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .procReadData(procReadData),
        .ir(ir),
        .procAddr(procAddr),
        .procWrite(procWrite),
        .procWriteData(procWriteData),
        .acc(acc),
        .pc(pc),
        .halted(halted)
    );

    unifiedMemory i_unifiedMemory (
        .clk(clk),
        .hostWrite(hostWrite),
        .hostAddr(hostAddr),
        .hostWriteData(hostWriteData),
        .hostReadData(hostReadData),
        .procAddr(procAddr),
        .procWrite(procWrite),
        .procWriteData(procWriteData),
        .procReadData(procReadData)
    );

endmodule

//--- tbTinyCpu.sv
`timescale 1ns/1ns

module tbTinyCpu;
    import cpuPkg::*;

    logic clk;
    logic rst;
    logic hostWrite;
    addr_t hostAddr;
    word_t hostWriteData;
    word_t hostReadData;
    data_t acc;
    addr_t pc;
    logic halted;

    // program image loaded from address 0
    word_t prog[$];
    string testName;
    int testErrors;
    int totalErrors;
    int checkCount;
    int passCount;
    int failCount;
    // running cycles against a limit that starts at the margin
    int runCycles;
    int cycleLimit;
    logic [31:0] lfsr;

    tinyCpu i_tinyCpu (
        .clk(clk),
        .rst(rst),
        .hostWrite(hostWrite),
        .hostAddr(hostAddr),
        .hostWriteData(hostWriteData),
        .hostReadData(hostReadData),
        .acc(acc),
        .pc(pc),
        .halted(halted)
    );

    always #10 clk = !clk;

    // only cycles with the processor running count
    always @(posedge clk) begin
        if (rst && !halted) begin
            runCycles++;
        end
        if (runCycles > cycleLimit) begin
            $display("timeout: processor never halted");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one step per bit taken
    task automatic takeBits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = nextLfsr(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    // opcode, mode, two zero bits, operand
    function automatic word_t aluInstr(opcode_e op, mode_e mode, data_t operand);
        return {op, mode, 2'b00, operand};
    endfunction

    // opcode, condition, target
    function automatic word_t jumpInstr(cond_e cond, addr_t target);
        return {JMP, cond, target};
    endfunction

    // background word that differs in every address bit
    function automatic word_t fillWord(addr_t addr);
        return {~addr, addr};
    endfunction

    task automatic compareData(input string what, input data_t expected, input data_t actual);
        checkCount++;
        if (actual !== expected) begin
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic compareAddr(input string what, input addr_t expected, input addr_t actual);
        checkCount++;
        if (actual !== expected) begin
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic compareWord(input string what, input word_t expected, input word_t actual);
        checkCount++;
        if (actual !== expected) begin
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    // host write lands on the following edge
    task automatic writeWord(input addr_t addr, input word_t data);
        @(posedge clk);
        hostWrite <= 1'b1;
        hostAddr <= addr;
        hostWriteData <= data;
    endtask

    // combinational read sampled mid cycle
    task automatic readWord(input addr_t addr, output word_t data);
        @(posedge clk);
        hostAddr <= addr;
        @(negedge clk);
        data = hostReadData;
    endtask

    // processor held in reset while the host loads
    task automatic startTest(input string name);
        testName = name;
        testErrors = 0;
        prog.delete();
        @(posedge clk);
        rst <= 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic runProgram();
        foreach (prog[i]) begin
            writeWord(addr_t'(i), prog[i]);
        end
        @(posedge clk);
        hostWrite <= 1'b0;
        // without backward jumps the length bounds the instructions run
        cycleLimit += 3 + 4 * prog.size();
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        while (!halted) begin
            @(negedge clk);
        end
    endtask

    task automatic finishTest();
        totalErrors += testErrors;
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
            passCount++;
        end else begin
            $display("test %s: %0d mismatches", testName, testErrors);
            failCount++;
        end
    endtask

    task automatic immediateTest();
        startTest("immediate");
        prog.push_back(aluInstr(LDA, IMM, 8'h5a));
        prog.push_back(aluInstr(ADD, IMM, 8'hc3));
        prog.push_back(aluInstr(SUB, IMM, 8'h27));
        prog.push_back(aluInstr(AND, IMM, 8'hf0));
        prog.push_back(aluInstr(HLT, IMM, 8'h00));
        runProgram();
        compareData("acc", data_t'((8'h5a + 8'hc3 - 8'h27) & 8'hf0), acc);
        compareAddr("pc", 8'd5, pc);
        finishTest();
    endtask

    task automatic directTest();
        word_t word;
        startTest("direct");
        // stale value the store must replace
        writeWord(8'h40, 16'hffff);
        prog.push_back(aluInstr(LDA, IMM, 8'h37));
        prog.push_back(aluInstr(STA, DIR, 8'h40));
        prog.push_back(aluInstr(LDA, IMM, 8'h05));
        prog.push_back(aluInstr(ADD, DIR, 8'h40));
        prog.push_back(aluInstr(HLT, IMM, 8'h00));
        runProgram();
        compareData("acc", 8'h37 + 8'h05, acc);
        compareAddr("pc", 8'd5, pc);
        readWord(8'h40, word);
        compareWord("stored word", 16'h0037, word);
        finishTest();
    endtask

    task automatic indirectTest();
        word_t word;
        startTest("indirect");
        // load pointer, store pointer, operand with a busy high byte
        writeWord(8'h50, 16'h0060);
        writeWord(8'h51, 16'h0070);
        writeWord(8'h60, 16'h12a5);
        prog.push_back(aluInstr(LDA, IND, 8'h50));
        prog.push_back(aluInstr(ADD, IMM, 8'h10));
        prog.push_back(aluInstr(STA, IND, 8'h51));
        prog.push_back(aluInstr(HLT, IMM, 8'h00));
        runProgram();
        compareData("acc", 8'ha5 + 8'h10, acc);
        compareAddr("pc", 8'd4, pc);
        readWord(8'h70, word);
        compareWord("pointed word", 16'h00b5, word);
        readWord(8'h50, word);
        compareWord("load pointer", 16'h0060, word);
        readWord(8'h51, word);
        compareWord("store pointer", 16'h0070, word);
        finishTest();
    endtask

    task automatic jumpTest();
        startTest("jumps");
        prog.push_back(aluInstr(LDA, IMM, 8'h00));
        prog.push_back(jumpInstr(ZERO, 8'd3));
        prog.push_back(aluInstr(ADD, IMM, 8'h01));
        prog.push_back(jumpInstr(NONZERO, 8'd5));
        prog.push_back(aluInstr(ADD, IMM, 8'h02));
        prog.push_back(jumpInstr(ZERO, 8'd7));
        prog.push_back(aluInstr(ADD, IMM, 8'h04));
        prog.push_back(jumpInstr(NONZERO, 8'd9));
        prog.push_back(aluInstr(ADD, IMM, 8'h08));
        prog.push_back(jumpInstr(NEG, 8'd11));
        prog.push_back(aluInstr(ADD, IMM, 8'h80));
        prog.push_back(jumpInstr(NEG, 8'd13));
        prog.push_back(aluInstr(ADD, IMM, 8'h10));
        prog.push_back(jumpInstr(ALWAYS, 8'd15));
        prog.push_back(aluInstr(ADD, IMM, 8'h20));
        prog.push_back(aluInstr(HLT, IMM, 8'h00));
        runProgram();
        // zero taken, nonzero not, zero not, nonzero taken, neg not, neg taken, always
        compareData("acc", 8'h02 + 8'h04 + 8'h80, acc);
        compareAddr("pc", 8'd16, pc);
        finishTest();
    endtask

    task automatic randomChainTest();
        data_t expected;
        logic [7:0] value;
        logic [7:0] bits;
        opcode_e op;
        addr_t dataAddr;
        startTest("random chain");
        takeBits(8, value);
        expected = value;
        prog.push_back(aluInstr(LDA, IMM, value));
        for (int i = 0; i < 12; i++) begin
            // bit 1 picks SUB and bit 0 a direct operand
            takeBits(2, bits);
            takeBits(8, value);
            op = bits[1] ? SUB : ADD;
            dataAddr = addr_t'(8'h80 + i);
            if (bits[0]) begin
                writeWord(dataAddr, word_t'(value));
                prog.push_back(aluInstr(op, DIR, dataAddr));
            end else begin
                prog.push_back(aluInstr(op, IMM, value));
            end
            expected = (op == ADD) ? expected + value : expected - value;
        end
        prog.push_back(aluInstr(HLT, IMM, 8'h00));
        runProgram();
        compareData("acc", expected, acc);
        compareAddr("pc", 8'd14, pc);
        finishTest();
    endtask

    task automatic haltHoldTest();
        word_t expected;
        word_t word;
        startTest("halt holds");
        // known background in every word
        for (int a = 0; a < memDepth; a++) begin
            writeWord(addr_t'(a), fillWord(addr_t'(a)));
        end
        // code past HLT must never run
        prog.push_back(aluInstr(LDA, IMM, 8'h99));
        prog.push_back(aluInstr(STA, DIR, 8'h20));
        prog.push_back(aluInstr(HLT, IMM, 8'h00));
        prog.push_back(aluInstr(LDA, IMM, 8'h11));
        prog.push_back(aluInstr(STA, DIR, 8'h20));
        runProgram();
        repeat (20) @(negedge clk);
        if (!halted) begin
            $display("test %s: halted dropped while rst stayed high", testName);
            testErrors++;
        end
        compareData("acc", 8'h99, acc);
        compareAddr("pc", 8'd3, pc);
        for (int a = 0; a < memDepth; a++) begin
            if (a < prog.size()) begin
                expected = prog[a];
            end else if (a == 8'h20) begin
                expected = 16'h0099;
            end else begin
                expected = fillWord(addr_t'(a));
            end
            readWord(addr_t'(a), word);
            compareWord($sformatf("word %02h", a), expected, word);
        end
        finishTest();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        hostWrite = 1'b0;
        hostAddr = '0;
        hostWriteData = '0;
        lfsr = 32'hfa3bca07;
        runCycles = 0;
        cycleLimit = 100;
        totalErrors = 0;
        checkCount = 0;
        passCount = 0;
        failCount = 0;
        immediateTest();
        directTest();
        indirectTest();
        jumpTest();
        randomChainTest();
        haltHoldTest();
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
            passCount, failCount, checkCount, totalErrors);
        if (failCount == 0 && totalErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- compile.f
cpuPkg.sv
timingGenerator.sv
microDecoder.sv
cpuDatapath.sv
unifiedMemory.sv
tinyCpu.sv
tbTinyCpu.sv

//--- Makefile
TOP = tbTinyCpu

.PHONY: lint sim clean

lint:
	verilator --lint-only cpuPkg.sv timingGenerator.sv microDecoder.sv cpuDatapath.sv \
		unifiedMemory.sv tinyCpu.sv --top-module tinyCpu
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o simTinyCpu
	@out=$$(./obj_dir/simTinyCpu); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
